/* arm_mem_pkg.sv */
`default_nettype none

package arm_mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_num_t;
	typedef logic [15:0] reg_list_t;

	typedef enum logic [1:0] {
		cls_none,
		cls_single,
		cls_swap,
		cls_block
	} mem_class_t;

	// ------------------------------------------------------------
	// instruction fields
	// ------------------------------------------------------------
	localparam int bit_load      = 20;
	localparam int bit_writeback = 21;
	localparam int bit_byte      = 22;
	localparam int bit_up        = 23;
	localparam int bit_pre       = 24;

	localparam int rd_hi = 15;
	localparam int rd_lo = 12;
	localparam int rn_hi = 19;
	localparam int rn_lo = 16;

	// class patterns, compared as (insn & mask) == match
	localparam word_t single_mask  = 32'h0c00_0000;
	localparam word_t single_match = 32'h0400_0000;
	localparam word_t block_mask   = 32'h0e00_0000;
	localparam word_t block_match  = 32'h0800_0000;
	localparam word_t swap_mask    = 32'h0fb0_0ff0;
	localparam word_t swap_match   = 32'h0100_0090;

	typedef enum logic {sgl_xfer, sgl_wb} single_state_t;
	typedef enum logic {swp_rd, swp_wr} swap_state_t;
	typedef enum logic [1:0] {blk_load_list, blk_transfer, blk_wb} block_state_t;

endpackage

`default_nettype wire

/* load_align.sv */
`default_nettype none

module load_align (
	input  wire arm_mem_pkg::word_t rd_data,
	input  wire arm_mem_pkg::word_t addr,
	input  wire                     byte_sel,
	output arm_mem_pkg::word_t      aligned
);

	logic [63:0] doubled;
	arm_mem_pkg::word_t rotated;

	assign doubled = {rd_data, rd_data}; // rotate by part-select
	assign rotated = doubled[8 * addr[1:0] +: 32];

	// byte loads take the addressed byte, zero-extended
	assign aligned = byte_sel ? {24'h000000, rotated[7:0]} : rotated;

endmodule

`default_nettype wire

/* ldm_sequencer.sv */
`default_nettype none

module ldm_sequencer (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         load,
	input  wire                         step,
	input  wire arm_mem_pkg::reg_list_t list,
	input  wire                         descending,
	output arm_mem_pkg::reg_num_t       cur_reg,
	output logic                        last
);

	arm_mem_pkg::reg_list_t remain;
	arm_mem_pkg::reg_list_t loaded;
	arm_mem_pkg::reg_num_t low_idx;

	// descending lists are stored mirrored
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			loaded[i] = descending ? list[15 - i] : list[i];
		end
	end

	always_comb begin
		low_idx = 4'h0;
		for (int i = 15; i >= 0; i--) begin
			if (remain[i])
				low_idx = 4'(i);
		end
	end

	assign cur_reg = descending ? 4'hf - low_idx : low_idx;
	assign last    = (remain & (remain - 16'd1)) == 16'd0; // at most one bit left

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			remain <= '0;
		end else if (load) begin
			remain <= loaded;
		end else if (step) begin
			remain <= remain & (remain - 16'd1); // drop lowest set bit
		end
	end

endmodule

`default_nettype wire

/* data_ram.sv */
`default_nettype none

module data_ram #(
	parameter int WAIT_CYCLES = 1,
	parameter int RAM_WORDS   = 256
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire arm_mem_pkg::word_t busaddr,
	input  wire arm_mem_pkg::word_t wr_data,
	input  wire                     rd_req,
	input  wire                     wr_req,
	output arm_mem_pkg::word_t      rd_data,
	output logic                    rw_wait
);

	localparam int AW = $clog2(RAM_WORDS);

	arm_mem_pkg::word_t mem [RAM_WORDS];
	arm_mem_pkg::word_t last_addr;
	logic [AW-1:0] idx;
	logic active;
	logic in_acc; // access started, waits still running
	logic first;
	logic [2:0] cnt;
	logic [2:0] remaining;

	assign idx     = busaddr[AW+1:2];
	assign active  = rd_req | wr_req;
	assign first   = ~in_acc | (busaddr[31:2] != last_addr[31:2]);

	assign remaining = first ? 3'(WAIT_CYCLES) : cnt;
	assign rw_wait   = active & (remaining != 3'd0);
	assign rd_data   = mem[idx];

	// ------------------------------------------------------------
	// wait counter and write port
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_acc    <= 1'b0;
			cnt       <= 3'd0;
			last_addr <= '0;
			for (int i = 0; i < RAM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			last_addr <= busaddr;
			if (!active) begin
				in_acc <= 1'b0;
			end else if (rw_wait) begin
				in_acc <= 1'b1;
				cnt    <= remaining - 3'd1;
			end else begin
				in_acc <= 1'b0; // access completes here
				if (wr_req)
					mem[idx] <= wr_data;
			end
		end
	end

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire arm_mem_pkg::reg_num_t st_read,
	output arm_mem_pkg::word_t         st_data,
	input  wire                        we,
	input  wire arm_mem_pkg::reg_num_t wnum,
	input  wire arm_mem_pkg::word_t    wdata
);

	arm_mem_pkg::word_t regs [16];

	assign st_data = regs[st_read]; // store data read port

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wnum] <= wdata;
		end
	end

endmodule

`default_nettype wire

/* mem_stage.sv */
`default_nettype none

module mem_stage (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        flush,
	input  wire                        inbubble,
	input  wire arm_mem_pkg::word_t    insn,
	input  wire arm_mem_pkg::word_t    op0,
	input  wire arm_mem_pkg::word_t    op1,
	input  wire arm_mem_pkg::word_t    op2,
	input  wire                        write_reg,
	input  wire arm_mem_pkg::reg_num_t write_num,
	input  wire arm_mem_pkg::word_t    write_data,
	output arm_mem_pkg::word_t         busaddr,
	output arm_mem_pkg::word_t         wr_data,
	output logic                       rd_req,
	output logic                       wr_req,
	input  wire arm_mem_pkg::word_t    rd_data,
	input  wire                        rw_wait,
	output arm_mem_pkg::reg_num_t      st_read,
	input  wire arm_mem_pkg::word_t    st_data,
	output logic                       outstall,
	output logic                       outbubble,
	output arm_mem_pkg::word_t         outinsn,
	output logic                       out_write_reg,
	output arm_mem_pkg::reg_num_t      out_write_num,
	output arm_mem_pkg::word_t         out_write_data
);

	arm_mem_pkg::mem_class_t cls;
	arm_mem_pkg::single_state_t sgl_state, sgl_next;
	arm_mem_pkg::swap_state_t swp_state, swp_next;
	arm_mem_pkg::block_state_t blk_state, blk_next;
	logic [6:0] offset, offset_next, off_sel;
	arm_mem_pkg::word_t swp_old;
	logic swp_capture;
	arm_mem_pkg::word_t sum, xfer_addr, blk_addr, blk_base, aligned;
	arm_mem_pkg::reg_num_t rd_num, rn_num, seq_reg;
	logic is_load, wb_en, seq_load, seq_step, seq_last;
	logic next_outbubble, next_write_reg;
	arm_mem_pkg::reg_num_t next_write_num;
	arm_mem_pkg::word_t next_write_data;

	always_comb begin
		if (inbubble)
			cls = arm_mem_pkg::cls_none;
		else if ((insn & arm_mem_pkg::swap_mask) == arm_mem_pkg::swap_match)
			cls = arm_mem_pkg::cls_swap;
		else if ((insn & arm_mem_pkg::single_mask) == arm_mem_pkg::single_match)
			cls = arm_mem_pkg::cls_single;
		else if ((insn & arm_mem_pkg::block_mask) == arm_mem_pkg::block_match)
			cls = arm_mem_pkg::cls_block;
		else
			cls = arm_mem_pkg::cls_none;
	end

	assign rd_num  = insn[arm_mem_pkg::rd_hi:arm_mem_pkg::rd_lo];
	assign rn_num  = insn[arm_mem_pkg::rn_hi:arm_mem_pkg::rn_lo];
	assign is_load = insn[arm_mem_pkg::bit_load];

	assign sum       = insn[arm_mem_pkg::bit_up] ? op0 + op1 : op0 - op1;
	assign xfer_addr = insn[arm_mem_pkg::bit_pre] ? sum : op0; // post-index uses base
	assign wb_en     = insn[arm_mem_pkg::bit_writeback] | ~insn[arm_mem_pkg::bit_pre];

	assign off_sel  = insn[arm_mem_pkg::bit_pre] ? offset + 7'd4 : offset;
	assign blk_addr = insn[arm_mem_pkg::bit_up] ? op0 + {25'b0, off_sel} : op0 - {25'b0, off_sel};
	assign blk_base = insn[arm_mem_pkg::bit_up] ? op0 + {25'b0, offset} : op0 - {25'b0, offset};

	assign st_read = seq_reg;

	load_align u_align (
		.rd_data  (rd_data),
		.addr     (xfer_addr),
		.byte_sel (insn[arm_mem_pkg::bit_byte]),
		.aligned  (aligned)
	);

	ldm_sequencer u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (seq_load),
		.step       (seq_step),
		.list       (op1[15:0]),
		.descending (~insn[arm_mem_pkg::bit_up]),
		.cur_reg    (seq_reg),
		.last       (seq_last)
	);

	// ------------------------------------------------------------
	// bus control and next write-back
	// ------------------------------------------------------------
	always_comb begin
		busaddr         = {xfer_addr[31:2], 2'b00};
		wr_data         = op2;
		rd_req          = 1'b0;
		wr_req          = 1'b0;
		outstall        = 1'b0;
		next_outbubble  = inbubble;
		next_write_reg  = write_reg;
		next_write_num  = write_num;
		next_write_data = write_data;
		sgl_next        = sgl_state;
		swp_next        = swp_state;
		blk_next        = blk_state;
		offset_next     = offset;
		swp_capture     = 1'b0;
		seq_load        = 1'b0;
		seq_step        = 1'b0;

		if (flush) begin
			next_outbubble = 1'b1;
			next_write_reg = 1'b0;
			sgl_next       = arm_mem_pkg::sgl_xfer;
			swp_next       = arm_mem_pkg::swp_rd;
			blk_next       = arm_mem_pkg::blk_load_list;
		end else begin
			case (cls)
			arm_mem_pkg::cls_single: begin
				next_write_reg = 1'b0;
				wr_data = insn[arm_mem_pkg::bit_byte] ? {4{op2[7:0]}} : op2;
				if (sgl_state == arm_mem_pkg::sgl_xfer) begin
					rd_req   = is_load;
					wr_req   = ~is_load;
					outstall = rw_wait | wb_en; // extra cycle for base update
					if (!rw_wait) begin
						if (is_load) begin
							next_write_reg  = 1'b1;
							next_write_num  = rd_num;
							next_write_data = aligned;
						end
						if (wb_en)
							sgl_next = arm_mem_pkg::sgl_wb;
					end
				end else begin
					next_write_reg  = 1'b1;
					next_write_num  = rn_num;
					next_write_data = sum;
					sgl_next        = arm_mem_pkg::sgl_xfer;
				end
				next_outbubble = outstall;
			end
			arm_mem_pkg::cls_swap: begin
				next_write_reg = 1'b0;
				busaddr = {op0[31:2], 2'b00};
				if (swp_state == arm_mem_pkg::swp_rd) begin
					rd_req   = 1'b1;
					outstall = 1'b1;
					if (!rw_wait) begin
						swp_capture = 1'b1;
						swp_next    = arm_mem_pkg::swp_wr;
					end
				end else begin
					wr_req   = 1'b1;
					outstall = rw_wait;
					if (!rw_wait) begin
						next_write_reg  = 1'b1;
						next_write_num  = rd_num;
						next_write_data = swp_old; // old memory word to rd
						swp_next        = arm_mem_pkg::swp_rd;
					end
				end
				next_outbubble = outstall;
			end
			arm_mem_pkg::cls_block: begin
				next_write_reg = 1'b0;
				busaddr = {blk_addr[31:2], 2'b00};
				wr_data = st_data;
				case (blk_state)
				arm_mem_pkg::blk_load_list: begin
					outstall    = 1'b1;
					seq_load    = 1'b1;
					offset_next = 7'd0;
					blk_next    = arm_mem_pkg::blk_transfer;
				end
				arm_mem_pkg::blk_transfer: begin
					rd_req   = is_load;
					wr_req   = ~is_load;
					outstall = 1'b1;
					if (!rw_wait) begin
						seq_step    = 1'b1;
						offset_next = offset + 7'd4;
						if (is_load) begin
							next_write_reg  = 1'b1;
							next_write_num  = seq_reg;
							next_write_data = rd_data;
						end
						if (seq_last)
							blk_next = arm_mem_pkg::blk_wb;
					end
				end
				default: begin
					next_write_reg  = 1'b1;
					next_write_num  = rn_num;
					next_write_data = blk_base;
					blk_next        = arm_mem_pkg::blk_load_list;
				end
				endcase
				next_outbubble = outstall;
			end
			default: begin
			end
			endcase
		end
	end

	// ------------------------------------------------------------
	// state and pipeline registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sgl_state     <= arm_mem_pkg::sgl_xfer;
			swp_state     <= arm_mem_pkg::swp_rd;
			blk_state     <= arm_mem_pkg::blk_load_list;
			offset        <= 7'd0;
			outbubble     <= 1'b1;
			out_write_reg <= 1'b0;
		end else begin
			sgl_state     <= sgl_next;
			swp_state     <= swp_next;
			blk_state     <= blk_next;
			offset        <= offset_next;
			outbubble     <= next_outbubble;
			out_write_reg <= next_write_reg;
		end
	end

	always_ff @(posedge clk) begin
		outinsn        <= insn;
		out_write_num  <= next_write_num;
		out_write_data <= next_write_data;
		if (swp_capture)
			swp_old <= rd_data;
	end

endmodule

`default_nettype wire

/* mem_subsys.sv */
`default_nettype none

module mem_subsys #(
	parameter int WAIT_CYCLES = 1,
	parameter int RAM_WORDS   = 256
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        inbubble,
	input  wire                        flush,
	input  wire arm_mem_pkg::word_t    insn,
	input  wire arm_mem_pkg::word_t    op0,
	input  wire arm_mem_pkg::word_t    op1,
	input  wire arm_mem_pkg::word_t    op2,
	input  wire                        write_reg,
	input  wire arm_mem_pkg::reg_num_t write_num,
	input  wire arm_mem_pkg::word_t    write_data,
	output wire                        outstall,
	output wire                        outbubble,
	output wire arm_mem_pkg::word_t    outinsn,
	output wire                        out_write_reg,
	output wire arm_mem_pkg::reg_num_t out_write_num,
	output wire arm_mem_pkg::word_t    out_write_data
);

	// data bus
	wire arm_mem_pkg::word_t busaddr;
	wire arm_mem_pkg::word_t wr_data;
	wire arm_mem_pkg::word_t rd_data;
	wire rd_req;
	wire wr_req;
	wire rw_wait;

	wire arm_mem_pkg::reg_num_t st_read; // store data port
	wire arm_mem_pkg::word_t st_data;

	mem_stage u_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.inbubble       (inbubble),
		.insn           (insn),
		.op0            (op0),
		.op1            (op1),
		.op2            (op2),
		.write_reg      (write_reg),
		.write_num      (write_num),
		.write_data     (write_data),
		.busaddr        (busaddr),
		.wr_data        (wr_data),
		.rd_req         (rd_req),
		.wr_req         (wr_req),
		.rd_data        (rd_data),
		.rw_wait        (rw_wait),
		.st_read        (st_read),
		.st_data        (st_data),
		.outstall       (outstall),
		.outbubble      (outbubble),
		.outinsn        (outinsn),
		.out_write_reg  (out_write_reg),
		.out_write_num  (out_write_num),
		.out_write_data (out_write_data)
	);

	data_ram #(
		.WAIT_CYCLES (WAIT_CYCLES),
		.RAM_WORDS   (RAM_WORDS)
	) u_ram (
		.clk     (clk),
		.rst_n   (rst_n),
		.busaddr (busaddr),
		.wr_data (wr_data),
		.rd_req  (rd_req),
		.wr_req  (wr_req),
		.rd_data (rd_data),
		.rw_wait (rw_wait)
	);

	reg_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.st_read (st_read),
		.st_data (st_data),
		.we      (out_write_reg),
		.wnum    (out_write_num),
		.wdata   (out_write_data)
	);

endmodule

`default_nettype wire

/* tb_mem_subsys.sv */
`default_nettype none

module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_VEC     = 64;
	localparam int WAIT_CYCLES = 1;

	logic clk;
	logic rst_n;
	logic inbubble;
	logic flush;
	logic write_reg;
	arm_mem_pkg::word_t insn;
	arm_mem_pkg::word_t op0;
	arm_mem_pkg::word_t op1;
	arm_mem_pkg::word_t op2;
	arm_mem_pkg::reg_num_t write_num;
	arm_mem_pkg::word_t write_data;

	wire outstall;
	wire outbubble;
	wire arm_mem_pkg::word_t outinsn;
	wire out_write_reg;
	wire arm_mem_pkg::reg_num_t out_write_num;
	wire arm_mem_pkg::word_t out_write_data;

	// one vector per line of the data file
	int vec_kind [MAX_VEC];
	arm_mem_pkg::word_t vec_insn [MAX_VEC];
	arm_mem_pkg::word_t vec_op0 [MAX_VEC];
	arm_mem_pkg::word_t vec_op1 [MAX_VEC];
	arm_mem_pkg::word_t vec_op2 [MAX_VEC];
	int exp_n [MAX_VEC];
	arm_mem_pkg::reg_num_t exp_num [MAX_VEC][4];
	arm_mem_pkg::word_t exp_val [MAX_VEC][4];
	int num_vec;
	logic vectors_read = 1'b0;

	// write-backs seen during the current test
	arm_mem_pkg::reg_num_t got_num [8];
	arm_mem_pkg::word_t got_data [8];
	int got_n;

	int error_count;
	int pass_count;
	int fail_count;

	mem_subsys #(
		.WAIT_CYCLES (WAIT_CYCLES),
		.RAM_WORDS   (256)
	) UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.inbubble       (inbubble),
		.flush          (flush),
		.insn           (insn),
		.op0            (op0),
		.op1            (op1),
		.op2            (op2),
		.write_reg      (write_reg),
		.write_num      (write_num),
		.write_data     (write_data),
		.outstall       (outstall),
		.outbubble      (outbubble),
		.outinsn        (outinsn),
		.out_write_reg  (out_write_reg),
		.out_write_num  (out_write_num),
		.out_write_data (out_write_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_word(input string name, input arm_mem_pkg::word_t expected,
			input arm_mem_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_reg(input string name, input arm_mem_pkg::reg_num_t expected,
			input arm_mem_pkg::reg_num_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_count(input int test, input string what, input int expected,
			input int actual);
		if (actual != expected) begin
			$display("test %0d gave %0d %s where %0d were expected",
				test, actual, what, expected);
			error_count++;
		end
	endtask

	// cycles with outstall high, from the ARM encoding
	function automatic int expected_stalls(input int kind, input arm_mem_pkg::word_t word,
			input arm_mem_pkg::word_t list);
		if (kind != 0)
			return 0;
		if (word[27:25] == 3'b100)
			return 1 + $countones(list[15:0]) * (WAIT_CYCLES + 1);
		if (word[27:23] == 5'b00010 && word[21:20] == 2'b00 && word[11:4] == 8'h09)
			return 2 * WAIT_CYCLES + 1;
		if (word[27:26] == 2'b01) begin
			if (!word[arm_mem_pkg::bit_pre] || word[arm_mem_pkg::bit_writeback])
				return WAIT_CYCLES + 1; // base write-back cycle
			return WAIT_CYCLES;
		end
		return 0;
	endfunction

	// ------------------------------------------------------------
	// vector file
	// ------------------------------------------------------------
	task automatic read_vectors();
		int fd;
		string line;
		logic [31:0] f_kind, f_insn, f_op0, f_op1, f_op2, f_n;
		logic [31:0] f_r0, f_v0, f_r1, f_v1, f_r2, f_v2, f_r3, f_v3;
		num_vec = 0;
		fd = $fopen("tb_vectors_input.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd) && num_vec < MAX_VEC) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f_kind, f_insn, f_op0, f_op1, f_op2, f_n,
						f_r0, f_v0, f_r1, f_v1, f_r2, f_v2, f_r3, f_v3) == 14) begin
					vec_kind[num_vec]   = f_kind;
					vec_insn[num_vec]   = f_insn;
					vec_op0[num_vec]    = f_op0;
					vec_op1[num_vec]    = f_op1;
					vec_op2[num_vec]    = f_op2;
					exp_n[num_vec]      = (f_n > 4) ? 4 : f_n;
					exp_num[num_vec][0] = f_r0[3:0];
					exp_val[num_vec][0] = f_v0;
					exp_num[num_vec][1] = f_r1[3:0];
					exp_val[num_vec][1] = f_v1;
					exp_num[num_vec][2] = f_r2[3:0];
					exp_val[num_vec][2] = f_v2;
					exp_num[num_vec][3] = f_r3[3:0];
					exp_val[num_vec][3] = f_v3;
					num_vec++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_idle();
		inbubble   = 1'b1;
		flush      = 1'b0;
		insn       = '0;
		op0        = '0;
		op1        = '0;
		op2        = '0;
		write_reg  = 1'b0;
		write_num  = '0;
		write_data = '0;
	endtask

	task automatic capture_writeback();
		if (out_write_reg) begin
			if (got_n < 8) begin
				got_num[got_n]  = out_write_num;
				got_data[got_n] = out_write_data;
			end
			got_n++;
		end
	endtask

	// kind 0 memory op, 1 pass-through write-back, 2 flush
	task automatic run_test(input int t);
		int err_before;
		int stalls;
		logic accepted;
		err_before = error_count;
		accepted   = 1'b0;
		stalls     = 0;
		got_n      = 0;
		@(posedge clk);
		#1;
		inbubble   = 1'b0;
		flush      = (vec_kind[t] == 2);
		insn       = vec_insn[t];
		op0        = vec_op0[t];
		op1        = vec_op1[t];
		op2        = vec_op2[t];
		write_reg  = (vec_kind[t] != 0);
		write_num  = vec_op0[t][3:0];
		write_data = vec_op2[t];
		while (!accepted) begin // inputs held while stalled
			@(negedge clk);
			capture_writeback();
			accepted = ~outstall;
			if (outstall)
				stalls++;
		end
		@(posedge clk);
		#1;
		drive_idle();
		@(negedge clk);
		capture_writeback(); // last write-back lands after the accepting edge
		check_flag("outbubble", vec_kind[t] == 2, outbubble);
		check_word("outinsn", vec_insn[t], outinsn);
		check_count(t, "stall cycles",
			expected_stalls(vec_kind[t], vec_insn[t], vec_op1[t]), stalls);
		check_count(t, "write-backs", exp_n[t], got_n);
		for (int i = 0; i < 4; i++) begin
			if (i < exp_n[t] && i < got_n) begin
				check_reg("out_write_num", exp_num[t][i], got_num[i]);
				check_word("out_write_data", exp_val[t][i], got_data[i]);
			end
		end
		if (error_count == err_before) begin
			pass_count++;
			$display("test %0d insn %h passed", t, vec_insn[t]);
		end else begin
			fail_count++;
			$display("test %0d insn %h failed", t, vec_insn[t]);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		rst_n       = 1'b0;
		drive_idle();
		error_count = 0;
		pass_count  = 0;
		fail_count  = 0;
		read_vectors();
		vectors_read = 1'b1;
		if (num_vec == 0) begin
			$display("no test vectors could be read from tb_vectors_input.txt");
			fail_count = 1;
		end else begin
			repeat (5) @(posedge clk);
			#1;
			rst_n = 1'b1;
			for (int t = 0; t < num_vec; t++) begin
				run_test(t);
			end
		end
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog sized from the vector count
	initial begin
		wait (vectors_read);
		repeat (num_vec * 40 + 50) @(posedge clk);
		$display("simulation timed out waiting for the memory stage");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_vectors_input.txt */
# kind insn op0 op1 op2 n_wb, then four (reg value) write-back pairs in order, all hex
# kind 0 memory op, 1 pass-through (op0 = write_num, op2 = write_data), 2 flush
0 e5a21000 00000100 00000010 cafef00d 1 2 00000110 0 00000000 0 00000000 0 00000000
0 e5923000 00000100 00000010 00000000 1 3 cafef00d 0 00000000 0 00000000 0 00000000
0 e5354000 00000120 00000010 00000000 2 4 cafef00d 5 00000110 0 00000000 0 00000000
0 e5801000 00000200 00000000 11223344 0 0 00000000 0 00000000 0 00000000 0 00000000
0 e5d06000 00000200 00000000 00000000 1 6 00000044 0 00000000 0 00000000 0 00000000
0 e5d06000 00000200 00000001 00000000 1 6 00000033 0 00000000 0 00000000 0 00000000
0 e5d06000 00000200 00000002 00000000 1 6 00000022 0 00000000 0 00000000 0 00000000
0 e5d06000 00000200 00000003 00000000 1 6 00000011 0 00000000 0 00000000 0 00000000
0 e4987000 00000110 00000008 00000000 2 7 cafef00d 8 00000118 0 00000000 0 00000000
0 e4187000 00000200 00000010 00000000 2 7 11223344 8 000001f0 0 00000000 0 00000000
1 e0810002 00000009 00000000 90909090 1 9 90909090 0 00000000 0 00000000 0 00000000
1 e0810002 0000000a 00000000 a5a5a5a5 1 a a5a5a5a5 0 00000000 0 00000000 0 00000000
1 e0810002 0000000b 00000000 b00b1e55 1 b b00b1e55 0 00000000 0 00000000 0 00000000
0 e8ac0e00 00000300 00000e00 00000000 1 c 0000030c 0 00000000 0 00000000 0 00000000
0 e8bd000e 00000300 0000000e 00000000 4 1 90909090 2 a5a5a5a5 3 b00b1e55 d 0000030c
0 e83d000e 00000308 0000000e 00000000 4 3 b00b1e55 2 a5a5a5a5 1 90909090 d 000002fc
0 e93d0070 0000030c 00000070 00000000 4 6 b00b1e55 5 a5a5a5a5 4 90909090 d 00000300
0 e10ae099 00000110 00000000 5a5a1234 1 e cafef00d 0 00000000 0 00000000 0 00000000
0 e5927000 00000100 00000010 00000000 1 7 5a5a1234 0 00000000 0 00000000 0 00000000
2 e5923000 00000100 00000010 12345678 0 0 00000000 0 00000000 0 00000000 0 00000000

/* src.f */
arm_mem_pkg.sv
load_align.sv
ldm_sequencer.sv
data_ram.sv
reg_file.sv
mem_stage.sv
mem_subsys.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_subsys -f src.f -o sim_mem_subsys
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
